/* sources.f */
bridge_bus_pkg.sv
bridge_msg_pkg.sv
msg_channel.sv
wb_msg_port.sv
delay_timer.sv
reg_bank.sv
cmd_engine.sv
msg_bridge_top.sv
tb_clkgen.sv
tb_msg_bridge.sv

/* Makefile */
all: run

obj_dir/Vtb_msg_bridge: sources.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_msg_bridge -f sources.f -o Vtb_msg_bridge

run: obj_dir/Vtb_msg_bridge
	-./obj_dir/Vtb_msg_bridge | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" sim.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* tb_msg_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_msg_bridge;

    import bridge_bus_pkg::*;
    import bridge_msg_pkg::*;

    // ack normally comes one edge after the request
    localparam int ack_limit  = 16;
    // a 200 cycle delay needs roughly 100 status polls
    localparam int poll_limit = 400;
    // engine side clock period in ns
    localparam realtime out_period = 14.0;

    logic       in_clk;
    logic       out_clk;
    logic       rst_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    integer     seed;
    // expected bank contents
    bank_data_t bank_model [16];
    logic [7:0] drop_model;

    tb_clkgen #(.half_period(5.0)) in_clk_gen (.clk(in_clk));
    tb_clkgen #(.half_period(out_period / 2.0)) out_clk_gen (.clk(out_clk));

    msg_bridge_top #(.cmd_len(32), .rsp_len(18), .count_bits(16)) dut0 (
        .in_clk(in_clk), .out_clk(out_clk), .rst_n(rst_n),
        .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic cmp_rsp(input string name, input rsp_msg_t exp, input rsp_msg_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected op %0d data %h, actual op %0d data %h",
                     $time, name, exp.op, exp.data, act.op, act.data);
            stop_with_failure();
        end
    endtask

    task automatic cmp_status(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h, actual %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic cmp_data(input string name, input bank_data_t exp, input bank_data_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h, actual %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    // waits for ack, ends the cycle, then checks ack fell again
    task automatic finish_access(input logic [1:0] adr, output logic [31:0] dat);
        int waited;
        waited = 0;
        @(negedge in_clk);
        while (!wb_rsp.ack) begin
            if (waited == ack_limit) begin
                $display("no ack from the bus slave for an access to address %0d", adr);
                stop_with_failure();
            end
            waited++;
            @(negedge in_clk);
        end
        dat = wb_rsp.dat;
        @(posedge in_clk);
        wb_req <= '0;
        @(negedge in_clk);
        if (wb_rsp.ack) begin
            $display("ack for address %0d stayed high for a second cycle", adr);
            stop_with_failure();
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
        wb_req_t     req;
        logic [31:0] unused_dat;
        req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        @(posedge in_clk);
        wb_req <= req;
        finish_access(adr, unused_dat);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
        wb_req_t req;
        req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
        @(posedge in_clk);
        wb_req <= req;
        finish_access(adr, dat);
    endtask

    // polls status until bit 0 shows the command channel free
    task automatic wait_tx_idle();
        logic [31:0] st;
        int          polls;
        polls = 0;
        wb_read(addr_status, st);
        while (!st[0]) begin
            if (polls == poll_limit) begin
                $display("command channel never returned to idle");
                stop_with_failure();
            end
            polls++;
            wb_read(addr_status, st);
        end
    endtask

    // polls for rx_valid, then pulls the response
    task automatic wait_rsp(output rsp_msg_t rsp);
        logic [31:0] st;
        logic [31:0] d;
        int          polls;
        polls = 0;
        wb_read(addr_status, st);
        while (!st[1]) begin
            if (polls == poll_limit) begin
                $display("no response arrived from the command engine");
                stop_with_failure();
            end
            polls++;
            wb_read(addr_status, st);
        end
        wb_read(addr_rx_rsp, d);
        rsp = d[17:0];
    endtask

    task automatic send_cmd(input cmd_msg_u cmd);
        wait_tx_idle();
        wb_write(addr_tx_cmd, cmd);
    endtask

    function automatic cmd_msg_u rw_cmd(input cmd_op_e op, input bank_addr_t a,
                                        input bank_data_t d);
        cmd_msg_u c;
        c.rw.op   = op;
        c.rw.pad  = '0;
        c.rw.addr = a;
        c.rw.data = d;
        return c;
    endfunction

    function automatic cmd_msg_u delay_cmd(input logic [15:0] n);
        cmd_msg_u c;
        c.dly.op    = op_delay;
        c.dly.pad   = '0;
        c.dly.count = n;
        return c;
    endfunction

    function automatic rsp_msg_t make_rsp(input cmd_op_e op, input bank_data_t d);
        rsp_msg_t r;
        r.op   = op;
        r.data = d;
        return r;
    endfunction

    // tx idle, nothing received, no drops
    task automatic after_reset();
        logic [31:0] st;
        wb_read(addr_status, st);
        cmp_status("status after reset", 32'h0000_0001, st);
    endtask

    task automatic write_readback();
        bank_addr_t a;
        bank_data_t d;
        rsp_msg_t   rsp;
        for (int i = 0; i < 10; i++) begin
            a = bank_addr_t'($random(seed));
            d = bank_data_t'($random(seed));
            send_cmd(rw_cmd(op_write, a, d));
            wait_rsp(rsp);
            cmp_rsp($sformatf("write rsp bank[%0d]", a), make_rsp(op_write, d), rsp);
            bank_model[a] = d;
        end
        // every address, written or still at reset value
        for (int i = 0; i < 16; i++) begin
            send_cmd(rw_cmd(op_read, bank_addr_t'(i), 16'h0000));
            wait_rsp(rsp);
            cmp_rsp($sformatf("read rsp bank[%0d]", i), make_rsp(op_read, bank_model[i]), rsp);
        end
    endtask

    task automatic delay_and_nop();
        logic [31:0] st;
        rsp_msg_t    rsp;
        realtime     t_sent;
        send_cmd(delay_cmd(16'd200));
        t_sent = $realtime;
        // no response before 200 out_clk cycles have passed
        while ($realtime - t_sent < 200 * out_period) begin
            wb_read(addr_status, st);
            cmp_status("status.rx_valid during delay", 32'h0, st & 32'h0000_0002);
        end
        wait_rsp(rsp);
        cmp_rsp("delay rsp", make_rsp(op_delay, 16'd200), rsp);
        // nop data field is ignored
        send_cmd(rw_cmd(op_nop, 4'h5, 16'h5a5a));
        wait_rsp(rsp);
        cmp_rsp("nop rsp", make_rsp(op_nop, 16'h0000), rsp);
    endtask

    task automatic back_to_back_drop();
        bank_addr_t  a_first;
        bank_addr_t  a_second;
        bank_data_t  d_first;
        bank_data_t  d_second;
        logic [31:0] st;
        rsp_msg_t    rsp;
        a_first  = 4'h3;
        a_second = 4'hc;
        d_first  = bank_data_t'($random(seed));
        // differs from the stored value so a leak would show
        d_second = ~bank_model[a_second];
        wait_tx_idle();
        wb_write(addr_tx_cmd, rw_cmd(op_write, a_first, d_first));
        wb_write(addr_tx_cmd, rw_cmd(op_write, a_second, d_second));
        drop_model = drop_model + 8'h01;
        bank_model[a_first] = d_first;
        wait_rsp(rsp);
        cmp_rsp("first of two writes", make_rsp(op_write, d_first), rsp);
        wb_read(addr_status, st);
        cmp_status("status.drop_count", {16'h0, drop_model, 8'h00}, st & 32'h0000_ff00);
        send_cmd(rw_cmd(op_read, a_second, 16'h0000));
        wait_rsp(rsp);
        cmp_data("bank at dropped write address", bank_model[a_second], rsp.data);
        send_cmd(rw_cmd(op_read, a_first, 16'h0000));
        wait_rsp(rsp);
        cmp_rsp("read of accepted write", make_rsp(op_read, d_first), rsp);
    endtask

    task automatic rx_clear_and_unused();
        logic [31:0] st;
        logic [31:0] d;
        rsp_msg_t    rsp;
        send_cmd(rw_cmd(op_read, 4'h7, 16'h0000));
        // saw rx_valid set, then read the rx register
        wait_rsp(rsp);
        cmp_rsp("read rsp bank[7]", make_rsp(op_read, bank_model[7]), rsp);
        wb_read(addr_status, st);
        cmp_status("status.rx_valid after rx read", 32'h0, st & 32'h0000_0002);
        wb_read(2'd3, d);
        cmp_status("unused address 3", 32'h0, d);
        wait_tx_idle();
        wb_read(addr_status, st);
        cmp_status("final status", {16'h0, drop_model, 8'h01}, st);
    endtask

    initial begin
        seed       = 32'h20f24e93;
        drop_model = 8'h00;
        for (int i = 0; i < 16; i++) begin
            bank_model[i] = '0;
        end
        rst_n  = 1'b0;
        wb_req = '0;
        repeat (16) @(posedge in_clk);
        rst_n <= 1'b1;
        after_reset();
        write_readback();
        delay_and_nop();
        back_to_back_drop();
        rx_clear_and_unused();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter realtime half_period = 5.0
) (
    output logic clk
);

    // starts low, first rising edge after one half period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(half_period);
        clk = ~clk;
    end

endmodule

`default_nettype wire

/* msg_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_bridge_top #(
    parameter int cmd_len    = 32,
    parameter int rsp_len    = 18,
    parameter int count_bits = 16
) (
    input  wire logic                    in_clk,
    input  wire logic                    out_clk,
    input  wire logic                    rst_n,
    input  wire bridge_bus_pkg::wb_req_t wb_req,
    output bridge_bus_pkg::wb_rsp_t      wb_rsp
);

    import bridge_msg_pkg::*;

    // command path, host side then engine side
    cmd_msg_u              host_cmd;
    logic                  host_cmd_trigger;
    logic                  cmd_idle;
    logic                  cmd_drop;
    cmd_msg_u              eng_cmd;
    logic                  eng_cmd_trigger;
    // response path, engine side then host side
    rsp_msg_t              eng_rsp;
    logic                  eng_rsp_trigger;
    logic                  rsp_idle;
    rsp_msg_t              host_rsp;
    logic                  host_rsp_trigger;
    // engine to bank and timer
    logic                  bank_we;
    bank_addr_t            bank_addr;
    bank_data_t            bank_wdata;
    bank_data_t            bank_rdata;
    logic                  timer_load;
    logic [count_bits-1:0] timer_count;
    logic                  timer_done;

    wb_msg_port u_port (
        .in_clk(in_clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .cmd_trigger(host_cmd_trigger), .cmd_msg(host_cmd),
        .cmd_idle(cmd_idle), .cmd_drop(cmd_drop),
        .rsp_trigger(host_rsp_trigger), .rsp_msg(host_rsp)
    );

    msg_channel #(.msg_len(cmd_len)) u_cmd_chan (
        .in_clk(in_clk), .out_clk(out_clk), .rst_n(rst_n),
        .trigger(host_cmd_trigger), .msg(host_cmd), .idle(cmd_idle), .drop(cmd_drop),
        .out_trigger(eng_cmd_trigger), .out_msg(eng_cmd)
    );

    // engine sends only when idle, so no drops on this side
    msg_channel #(.msg_len(rsp_len)) u_rsp_chan (
        .in_clk(out_clk), .out_clk(in_clk), .rst_n(rst_n),
        .trigger(eng_rsp_trigger), .msg(eng_rsp), .idle(rsp_idle), .drop(),
        .out_trigger(host_rsp_trigger), .out_msg(host_rsp)
    );

    cmd_engine u_engine (
        .in_clk(out_clk), .rst_n(rst_n),
        .cmd_trigger(eng_cmd_trigger), .cmd_msg(eng_cmd),
        .bank_we(bank_we), .bank_addr(bank_addr), .bank_wdata(bank_wdata),
        .bank_rdata(bank_rdata), .timer_load(timer_load), .timer_count(timer_count),
        .timer_done(timer_done), .rsp_idle(rsp_idle),
        .rsp_trigger(eng_rsp_trigger), .rsp_msg(eng_rsp)
    );

    delay_timer #(.count_bits(count_bits)) u_timer (
        .in_clk(out_clk), .rst_n(rst_n),
        .load(timer_load), .count(timer_count), .done(timer_done)
    );

    reg_bank u_bank (
        .in_clk(out_clk), .rst_n(rst_n), .we(bank_we),
        .addr(bank_addr), .wdata(bank_wdata), .rdata(bank_rdata)
    );

endmodule

`default_nettype wire

/* cmd_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_engine (
    input  wire logic                     in_clk,
    input  wire logic                     rst_n,
    input  wire logic                     cmd_trigger,
    input  wire bridge_msg_pkg::cmd_msg_u cmd_msg,
    output logic                          bank_we,
    output bridge_msg_pkg::bank_addr_t    bank_addr,
    output bridge_msg_pkg::bank_data_t    bank_wdata,
    input  wire bridge_msg_pkg::bank_data_t bank_rdata,
    output logic                          timer_load,
    output logic [15:0]                   timer_count,
    input  wire logic                     timer_done,
    input  wire logic                     rsp_idle,
    output logic                          rsp_trigger,
    output bridge_msg_pkg::rsp_msg_t      rsp_msg
);

    import bridge_msg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_wait_timer,
        st_send
    } state_e;

    state_e  state;
    cmd_op_e op_q;
    logic    accept;

    // commands outside idle are ignored
    assign accept = (state == st_idle) && cmd_trigger;

    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            bank_we    <= 1'b0;
            timer_load <= 1'b0;
        end else begin
            bank_we    <= 1'b0;
            timer_load <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_trigger) begin
                        if (cmd_msg.rw.op == op_delay) begin
                            timer_load <= 1'b1;
                            state      <= st_wait_timer;
                        end else begin
                            // read and nop pass the bank untouched
                            bank_we <= (cmd_msg.rw.op == op_write);
                            state   <= st_exec;
                        end
                    end
                end
                // bank write or registered read in flight
                st_exec: state <= st_send;
                st_wait_timer: begin
                    if (timer_done) begin
                        state <= st_send;
                    end
                end
                // hold here until the response channel frees up
                st_send: begin
                    if (rsp_idle) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // both union views captured, op picks the one that counts
    always_ff @(posedge in_clk) begin
        if (accept) begin
            op_q        <= cmd_msg.rw.op;
            bank_addr   <= cmd_msg.rw.addr;
            bank_wdata  <= cmd_msg.rw.data;
            timer_count <= cmd_msg.dly.count;
        end
    end

    assign rsp_trigger = (state == st_send) && rsp_idle;

    // response data by op
    always_comb begin
        rsp_msg.op = op_q;
        case (op_q)
            op_write: rsp_msg.data = bank_wdata;
            op_read:  rsp_msg.data = bank_rdata;
            op_delay: rsp_msg.data = timer_count;
            default:  rsp_msg.data = '0;
        endcase
    end

    // every send is taken, the channel turns busy on the next edge
    a_rsp_send: assert property (@(posedge in_clk) disable iff (!rst_n)
        rsp_trigger |=> !rsp_idle);

endmodule

`default_nettype wire

/* reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
    input  wire logic                       in_clk,
    input  wire logic                       rst_n,
    input  wire logic                       we,
    input  wire bridge_msg_pkg::bank_addr_t addr,
    input  wire bridge_msg_pkg::bank_data_t wdata,
    output bridge_msg_pkg::bank_data_t      rdata
);

    import bridge_msg_pkg::*;

    // one register per address
    localparam int depth = 2 ** $bits(bank_addr_t);

    bank_data_t regs [depth];

    // single write port
    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[addr] <= wdata;
        end
    end

    // registered read
    // same cycle write shows the old value
    always_ff @(posedge in_clk) begin
        rdata <= regs[addr];
    end

endmodule

`default_nettype wire

/* delay_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_timer #(
    parameter int count_bits = 16
) (
    input  wire logic                  in_clk,
    input  wire logic                  rst_n,
    input  wire logic                  load,
    input  wire logic [count_bits-1:0] count,
    output logic                       done
);

    // remaining cycles, zero when stopped
    logic [count_bits-1:0] cnt;

    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            if (load) begin
                cnt <= count;
            end else if (cnt != '0) begin
                cnt <= cnt - count_bits'(1);
            end
            // done N cycles after load
            // zero count still finishes, one cycle later
            done <= load ? (count == '0) : (cnt == count_bits'(1));
        end
    end

    // the engine reloads only after done
    a_no_reload: assert property (@(posedge in_clk) disable iff (!rst_n)
        load |-> (cnt == '0));

endmodule

`default_nettype wire

/* wb_msg_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_msg_port (
    input  wire logic                     in_clk,
    input  wire logic                     rst_n,
    input  wire bridge_bus_pkg::wb_req_t  wb_req,
    output bridge_bus_pkg::wb_rsp_t       wb_rsp,
    output logic                          cmd_trigger,
    output bridge_msg_pkg::cmd_msg_u      cmd_msg,
    input  wire logic                     cmd_idle,
    input  wire logic                     cmd_drop,
    input  wire logic                     rsp_trigger,
    input  wire bridge_msg_pkg::rsp_msg_t rsp_msg
);

    import bridge_bus_pkg::*;
    import bridge_msg_pkg::*;

    logic        ack_q;
    logic [31:0] rd_dat;
    reg_addr_e   addr;
    logic        access;
    logic        wr_tx;
    logic        rd_rx;
    cmd_msg_u    tx_q;
    rsp_msg_t    rx_q;
    logic        rx_valid;
    logic [7:0]  drop_cnt;
    logic [31:0] status_word;

    assign addr   = reg_addr_e'(wb_req.adr);
    // new cycle seen, ack not yet given
    assign access = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_tx  = access && wb_req.we && (addr == addr_tx_cmd);
    assign rd_rx  = access && !wb_req.we && (addr == addr_rx_rsp);

    // tx_idle bit 0, rx_valid bit 1, drops in 15:8
    assign status_word = {16'h0000, drop_cnt, 6'b000000, rx_valid, cmd_idle};

    // single cycle ack
    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // read data registered with the ack
    always_ff @(posedge in_clk) begin
        if (access && !wb_req.we) begin
            case (addr)
                addr_tx_cmd: rd_dat <= tx_q;
                addr_status: rd_dat <= status_word;
                addr_rx_rsp: rd_dat <= {14'h0000, rx_q};
                default:     rd_dat <= '0;
            endcase
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_dat};

    // tx command word
    always_ff @(posedge in_clk) begin
        if (wr_tx) begin
            tx_q <= cmd_msg_u'(wb_req.dat);
        end
    end

    assign cmd_msg = tx_q;

    // trigger lines up with the stored word
    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            cmd_trigger <= 1'b0;
        end else begin
            cmd_trigger <= wr_tx;
        end
    end

    // saturating drop count
    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            drop_cnt <= 8'h00;
        end else if (cmd_drop && (drop_cnt != 8'hff)) begin
            drop_cnt <= drop_cnt + 8'h01;
        end
    end

    // rx response, payload latched on arrival
    always_ff @(posedge in_clk) begin
        if (rsp_trigger) begin
            rx_q <= rsp_msg;
        end
    end

    // a new response wins over a clearing read
    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else if (rsp_trigger) begin
            rx_valid <= 1'b1;
        end else if (rd_rx) begin
            rx_valid <= 1'b0;
        end
    end

    // host drops stb once acked, so each access sees a single ack
    a_ack_single: assert property (@(posedge in_clk) disable iff (!rst_n)
        ack_q |=> !wb_req.stb);

endmodule

`default_nettype wire

/* msg_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_channel #(
    parameter int msg_len = 8
) (
    input  wire logic               in_clk,
    input  wire logic               out_clk,
    input  wire logic               rst_n,
    input  wire logic               trigger,
    input  wire logic [msg_len-1:0] msg,
    output logic                    idle,
    output logic                    drop,
    output logic                    out_trigger,
    output logic [msg_len-1:0]      out_msg
);

    // sender side, in_clk
    logic req;
    logic ack_meta;
    logic ack_sync;
    // receiver side, out_clk
    logic req_meta;
    logic req_sync;
    logic req_sync_d;

    // busy until the ack has come back and dropped again
    assign idle = !req && !ack_sync;
    // trigger while busy is lost
    assign drop = trigger && !idle;

    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            req <= 1'b0;
        end else if (idle && trigger) begin
            req <= 1'b1;
        end else if (ack_sync) begin
            req <= 1'b0;
        end
    end

    // payload captured on accept, held while req is open
    always_ff @(posedge in_clk) begin
        if (idle && trigger) begin
            out_msg <= msg;
        end
    end

    // ack back into in_clk
    always_ff @(posedge in_clk) begin
        if (!rst_n) begin
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end else begin
            ack_meta <= req_sync;
            ack_sync <= ack_meta;
        end
    end

    // req into out_clk, plus one stage for edge detect
    always_ff @(posedge out_clk) begin
        if (!rst_n) begin
            req_meta   <= 1'b0;
            req_sync   <= 1'b0;
            req_sync_d <= 1'b0;
        end else begin
            req_meta   <= req;
            req_sync   <= req_meta;
            req_sync_d <= req_sync;
        end
    end

    // rising edge of the synced req
    assign out_trigger = req_sync && !req_sync_d;

    // receiver reads out_msg at any time while its synced req is high
    a_msg_stable: assert property (@(posedge out_clk) disable iff (!rst_n)
        req_sync |-> $stable(out_msg));

endmodule

`default_nettype wire

/* bridge_msg_pkg.sv */
`default_nettype none

package bridge_msg_pkg;

    // register bank geometry
    typedef logic [3:0]  bank_addr_t;
    typedef logic [15:0] bank_data_t;

    typedef enum logic [1:0] {
        op_write = 2'd0,
        op_read  = 2'd1,
        op_delay = 2'd2,
        op_nop   = 2'd3
    } cmd_op_e;

    // bank access view of a command word
    typedef struct packed {
        cmd_op_e    op;
        logic [9:0] pad;
        bank_addr_t addr;
        bank_data_t data;
    } cmd_rw_t;

    // delay view, count in out_clk cycles
    typedef struct packed {
        cmd_op_e     op;
        logic [13:0] pad;
        logic [15:0] count;
    } cmd_delay_t;

    // op sits in the top two bits of both views
    typedef union packed {
        cmd_rw_t    rw;
        cmd_delay_t dly;
    } cmd_msg_u;

    // response, echoes the op
    typedef struct packed {
        cmd_op_e    op;
        bank_data_t data;
    } rsp_msg_t;

endpackage

`default_nettype wire

/* bridge_bus_pkg.sv */
`default_nettype none

package bridge_bus_pkg;

    // width of the host data bus
    localparam int wb_data_bits = 32;

    // host to slave, one classic cycle
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        // word address, four registers
        logic [1:0]              adr;
        logic [wb_data_bits-1:0] dat;
    } wb_req_t;

    // slave to host
    typedef struct packed {
        logic                    ack;
        logic [wb_data_bits-1:0] dat;
    } wb_rsp_t;

    // register map, 3 unused and reads zero
    typedef enum logic [1:0] {
        addr_tx_cmd = 2'd0,
        addr_status = 2'd1,
        addr_rx_rsp = 2'd2
    } reg_addr_e;

endpackage

`default_nettype wire
